//--- verilog/pcs_code_pkg.sv
`default_nettype none

package pcs_code_pkg;

	// One code group as seen on the SERDES byte interface
	typedef logic [7:0] code_byte_t;

	////////////////////////////////////////
	// Control symbols

	localparam code_byte_t k28_5 = 8'hbc;	// Comma, first byte of every ordered set
	localparam code_byte_t k27_7 = 8'hfb;	// Start of packet
	localparam code_byte_t k29_7 = 8'hfd;	// End of packet
	localparam code_byte_t k23_7 = 8'hf7;	// Carrier extend
	localparam code_byte_t k30_7 = 8'hfe;	// Error propagation

	////////////////////////////////////////
	// Data symbols used inside ordered sets

	localparam code_byte_t d21_5 = 8'hb5;	// /C1/ header
	localparam code_byte_t d2_2 = 8'h42;	// /C2/ header
	localparam code_byte_t d16_2 = 8'h50;	// /I2/ second byte
	localparam code_byte_t d5_6 = 8'hc5;	// /I1/ second byte, flips disparity

	// Put back in place of the start symbol on receive
	localparam code_byte_t preamble_byte = 8'h55;

endpackage

`default_nettype wire

//--- verilog/pcs_aneg_pkg.sv
`default_nettype none

package pcs_aneg_pkg;

	// Clause 37 arbitration states
	typedef enum logic [2:0] {
		ENABLE,
		RESTART,
		ABILITY_DETECT,
		ACK_DETECT,
		COMPLETE_ACK,
		IDLE_DETECT,
		LINK_OK
	} aneg_state_t;

	// Base page config register, low byte sent first
	typedef logic [15:0] cfg_word_t;

	////////////////////////////////////////
	// Bit positions in the base page

	localparam int cfg_ack_bit = 14;	// Acknowledge
	localparam int cfg_full_duplex_bit = 5;	// Full duplex ability

	// Back-to-back /I2/ sets needed before the partner counts as idle
	localparam int idle_match_count = 4;

endpackage

`default_nettype wire

//--- verilog/link_timer.sv
`default_nettype none
`timescale 1ns/10ps

module link_timer #(
	parameter int LINK_TIMER_CYCLES = 1250000	// 10 ms at 125 MHz
) (
	input wire logic clk_125mhz,
	input wire logic rst_n,
	input wire logic timer_start,
	output logic timer_done
);

	localparam int cnt_w = $clog2(LINK_TIMER_CYCLES + 1);

	logic [cnt_w-1:0] count;
	logic running;

	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			count <= '0;
			running <= 1'b0;
			timer_done <= 1'b0;
		end else begin
			timer_done <= 1'b0;
			if (timer_start) begin	// Restart wins over expiry
				count <= '0;
				running <= 1'b1;
			end else if (running) begin
				count <= count + 1'b1;
				if (count == cnt_w'(LINK_TIMER_CYCLES - 1)) begin
					timer_done <= 1'b1;	// Single pulse, then idle
					running <= 1'b0;
				end
			end
		end
	end

	// Expiry stops the counter, so a second pulse needs a new start
	a_done_single: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
		timer_done |=> !timer_done);

endmodule

`default_nettype wire

//--- verilog/rx_ordered_set_parser.sv
`default_nettype none
`timescale 1ns/10ps

module rx_ordered_set_parser (
	input wire logic clk_125mhz,
	input wire logic rst_n,
	input wire logic rx_valid,
	input wire logic rx_is_ctl,
	input wire pcs_code_pkg::code_byte_t rx_data,
	output logic cfg_valid,
	output pcs_aneg_pkg::cfg_word_t cfg_word,
	output logic idle_match
);

	typedef enum logic [1:0] {
		cap_wait_comma,
		cap_header,
		cap_low,
		cap_high
	} cap_state_t;

	cap_state_t cap_state;
	logic [7:0] cfg_low;	// First config byte, held until the second arrives
	logic last_was_comma;
	logic [2:0] idle_cnt;

	wire is_comma = rx_is_ctl && (rx_data == pcs_code_pkg::k28_5);

	////////////////////////////////////////
	// /C1/ and /C2/ capture

	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			cap_state <= cap_wait_comma;
			cfg_valid <= 1'b0;
			cfg_low <= '0;
			cfg_word <= '0;
		end else begin
			cfg_valid <= 1'b0;
			if (rx_valid) begin
				case (cap_state)
					cap_wait_comma: if (is_comma) cap_state <= cap_header;
					cap_header: begin
						cap_state <= cap_wait_comma;	// Not a config set
						if (!rx_is_ctl && (rx_data == pcs_code_pkg::d21_5 ||
							rx_data == pcs_code_pkg::d2_2))
							cap_state <= cap_low;	// Either header, no alternation check
					end
					cap_low: begin
						cfg_low <= rx_data;
						cap_state <= rx_is_ctl ? cap_wait_comma : cap_high;
					end
					default: begin	// High byte closes the set
						cap_state <= cap_wait_comma;
						if (!rx_is_ctl) begin
							cfg_word <= {rx_data, cfg_low};
							cfg_valid <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	////////////////////////////////////////
	// /I2/ run detection

	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			last_was_comma <= 1'b0;
			idle_cnt <= '0;
			idle_match <= 1'b0;
		end else if (rx_valid) begin
			last_was_comma <= is_comma;
			if (is_comma) begin
				// First half of a possible idle, leave the count alone
			end else if (!rx_is_ctl && rx_data == pcs_code_pkg::d16_2 && last_was_comma) begin
				if (idle_cnt == 3'(pcs_aneg_pkg::idle_match_count - 1))
					idle_match <= 1'b1;	// Count saturates here
				else
					idle_cnt <= idle_cnt + 3'd1;
			end else begin
				idle_cnt <= '0;	// Data, config or any other symbol
				idle_match <= 1'b0;
			end
		end
	end

	a_cfg_after_valid: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
		cfg_valid |-> $past(rx_valid));

endmodule

`default_nettype wire

//--- verilog/aneg_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module aneg_fsm (
	input wire logic clk_125mhz,
	input wire logic rst_n,
	input wire logic cfg_valid,
	input wire pcs_aneg_pkg::cfg_word_t cfg_word,
	input wire logic idle_match,
	input wire logic timer_done,
	output logic timer_start,
	output logic link_up,
	output logic send_idle,
	output pcs_aneg_pkg::cfg_word_t tx_cfg
);

	pcs_aneg_pkg::aneg_state_t state;
	pcs_aneg_pkg::cfg_word_t cfg_ff;	// Newest config word
	pcs_aneg_pkg::cfg_word_t cfg_ff2;	// The one before it
	logic cfg_match;	// Three equal words in a row

	////////////////////////////////////////
	// Config history

	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			cfg_ff <= '0;
			cfg_ff2 <= '0;
			cfg_match <= 1'b0;
		end else if (cfg_valid) begin
			cfg_ff <= cfg_word;
			cfg_ff2 <= cfg_ff;
			cfg_match <= (cfg_ff == cfg_word) && (cfg_ff2 == cfg_word);
		end
	end

	wire match_nonzero = cfg_match && (cfg_ff != '0);
	wire match_ack = cfg_match && cfg_ff[pcs_aneg_pkg::cfg_ack_bit];
	wire bad_duplex = match_nonzero && !cfg_ff[pcs_aneg_pkg::cfg_full_duplex_bit];
	wire partner_restart = (cfg_match && cfg_ff == '0) || bad_duplex;
	wire timer_expired = timer_done && !timer_start;	// Ignore a stale pulse right after a restart

	assign send_idle = (state == pcs_aneg_pkg::IDLE_DETECT);

	////////////////////////////////////////
	// Arbitration

	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			state <= pcs_aneg_pkg::ENABLE;
			timer_start <= 1'b0;
			link_up <= 1'b0;
			tx_cfg <= '0;
		end else begin
			timer_start <= 1'b0;
			case (state)
				pcs_aneg_pkg::ENABLE: begin
					tx_cfg <= '0;	// Advertise nothing while restarting
					timer_start <= 1'b1;
					state <= pcs_aneg_pkg::RESTART;
				end
				pcs_aneg_pkg::RESTART: begin
					if (timer_expired) begin
						tx_cfg <= '0;
						tx_cfg[pcs_aneg_pkg::cfg_full_duplex_bit] <= 1'b1;	// Full duplex only
						state <= pcs_aneg_pkg::ABILITY_DETECT;
					end
				end
				pcs_aneg_pkg::ABILITY_DETECT: begin
					if (idle_match) begin	// Partner without autoneg, parallel detect
						link_up <= 1'b1;
						timer_start <= 1'b1;
						state <= pcs_aneg_pkg::LINK_OK;
					end else if (bad_duplex)
						state <= pcs_aneg_pkg::ENABLE;
					else if (match_nonzero)
						state <= pcs_aneg_pkg::ACK_DETECT;
				end
				pcs_aneg_pkg::ACK_DETECT: begin
					tx_cfg[pcs_aneg_pkg::cfg_ack_bit] <= 1'b1;	// Acknowledge partner page
					if (partner_restart)
						state <= pcs_aneg_pkg::ENABLE;
					else if (match_ack) begin
						timer_start <= 1'b1;
						state <= pcs_aneg_pkg::COMPLETE_ACK;
					end
				end
				pcs_aneg_pkg::COMPLETE_ACK: begin
					if (partner_restart)
						state <= pcs_aneg_pkg::ENABLE;
					else if (timer_expired) begin
						if (match_ack) begin
							timer_start <= 1'b1;
							state <= pcs_aneg_pkg::IDLE_DETECT;
						end else
							state <= pcs_aneg_pkg::ENABLE;	// Match lost during ack
					end
				end
				pcs_aneg_pkg::IDLE_DETECT: begin
					if (partner_restart)
						state <= pcs_aneg_pkg::ENABLE;
					else if (timer_expired && idle_match) begin
						link_up <= 1'b1;
						timer_start <= 1'b1;
						state <= pcs_aneg_pkg::LINK_OK;
					end else if (timer_expired)
						state <= pcs_aneg_pkg::ENABLE;	// Partner never went idle
				end
				default: begin	// LINK_OK
					if (idle_match)
						timer_start <= 1'b1;	// Idles keep the link alive
					if (timer_expired || cfg_valid) begin
						link_up <= 1'b0;
						state <= pcs_aneg_pkg::ENABLE;
					end
				end
			endcase
		end
	end

	a_link_state: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
		link_up == (state == pcs_aneg_pkg::LINK_OK));

endmodule

`default_nettype wire

//--- verilog/tx_encoder.sv
`default_nettype none
`timescale 1ns/10ps

module tx_encoder (
	input wire logic clk_125mhz,
	input wire logic rst_n,
	input wire logic link_up,
	input wire logic send_idle,
	input wire pcs_aneg_pkg::cfg_word_t tx_cfg,
	input wire logic gmii_tx_en,
	input wire logic [7:0] gmii_tx_data,
	input wire logic tx_disparity_negative,
	output logic tx_is_ctl,
	output pcs_code_pkg::code_byte_t tx_data,
	output logic tx_force_disparity_negative
);

	typedef enum logic [2:0] {
		st_idle_k,	// K28.5 of /I2/
		st_idle_d,	// D16.2 of /I2/
		st_start,	// Late start symbol
		st_frame,
		st_extend,
		st_i1_k,	// K28.5 of /I1/
		st_i1_d	// D5.6 of /I1/
	} frame_state_t;

	frame_state_t frame_state;
	logic late;	// Start was pushed back one byte by an idle in progress
	logic en_d;
	logic [7:0] data_d;
	logic link_is_ctl;
	pcs_code_pkg::code_byte_t link_data;
	logic [2:0] seq;
	logic aneg_is_ctl;
	logic aneg_force;
	pcs_code_pkg::code_byte_t aneg_data;

	// After a late start the frame runs one byte behind the GMII bus
	wire src_en = late ? en_d : gmii_tx_en;
	wire [7:0] src_data = late ? data_d : gmii_tx_data;

	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			en_d <= 1'b0;
			data_d <= '0;
		end else begin
			en_d <= gmii_tx_en;
			data_d <= gmii_tx_data;
		end
	end

	////////////////////////////////////////
	// Link path, idles and framed data

	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			frame_state <= st_idle_k;
			late <= 1'b0;
			link_is_ctl <= 1'b0;
			link_data <= '0;
		end else begin
			link_is_ctl <= 1'b0;
			case (frame_state)
				st_idle_k: begin
					link_is_ctl <= 1'b1;
					if (gmii_tx_en) begin	// Start replaces first preamble byte
						link_data <= pcs_code_pkg::k27_7;
						late <= 1'b0;
						frame_state <= st_frame;
					end else begin
						link_data <= pcs_code_pkg::k28_5;
						frame_state <= st_idle_d;
					end
				end
				st_idle_d: begin
					link_data <= pcs_code_pkg::d16_2;	// Always finish the idle set
					late <= gmii_tx_en;
					frame_state <= gmii_tx_en ? st_start : st_idle_k;
				end
				st_start: begin
					link_data <= pcs_code_pkg::k27_7;
					link_is_ctl <= 1'b1;
					frame_state <= st_frame;
				end
				st_frame: begin
					if (src_en)
						link_data <= src_data;
					else begin
						link_data <= pcs_code_pkg::k29_7;	// End of packet
						link_is_ctl <= 1'b1;
						frame_state <= st_extend;
					end
				end
				st_extend: begin
					link_data <= pcs_code_pkg::k23_7;
					link_is_ctl <= 1'b1;
					frame_state <= tx_disparity_negative ? st_idle_k : st_i1_k;
				end
				st_i1_k: begin
					link_data <= pcs_code_pkg::k28_5;
					link_is_ctl <= 1'b1;
					frame_state <= st_i1_d;
				end
				default: begin
					link_data <= pcs_code_pkg::d5_6;	// Brings disparity back negative
					frame_state <= st_idle_k;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Autonegotiation path

	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			seq <= '0;
			aneg_is_ctl <= 1'b0;
			aneg_force <= 1'b0;
			aneg_data <= '0;
		end else begin
			seq <= seq + 3'd1;
			aneg_is_ctl <= 1'b0;
			aneg_force <= 1'b0;
			if (send_idle) begin	// /I2/ pairs
				if (!seq[0]) begin
					aneg_data <= pcs_code_pkg::k28_5;
					aneg_is_ctl <= 1'b1;
					aneg_force <= 1'b1;
				end else
					aneg_data <= pcs_code_pkg::d16_2;
			end else begin
				case (seq)	// /C1/ then /C2/
					3'd0, 3'd4: begin
						aneg_data <= pcs_code_pkg::k28_5;
						aneg_is_ctl <= 1'b1;
					end
					3'd1: aneg_data <= pcs_code_pkg::d21_5;
					3'd5: aneg_data <= pcs_code_pkg::d2_2;
					3'd2, 3'd6: aneg_data <= tx_cfg[7:0];
					default: aneg_data <= tx_cfg[15:8];
				endcase
			end
		end
	end

	// Output select
	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			tx_is_ctl <= 1'b0;
			tx_data <= '0;
			tx_force_disparity_negative <= 1'b0;
		end else if (link_up) begin
			tx_is_ctl <= link_is_ctl;
			tx_data <= link_data;
			tx_force_disparity_negative <= 1'b0;
		end else begin
			tx_is_ctl <= aneg_is_ctl;
			tx_data <= aneg_data;
			tx_force_disparity_negative <= aneg_force;
		end
	end

	a_no_force_on_link: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
		link_up |=> !tx_force_disparity_negative);

endmodule

`default_nettype wire

//--- verilog/rx_frame_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module rx_frame_decoder (
	input wire logic clk_125mhz,
	input wire logic rst_n,
	input wire logic rx_valid,
	input wire logic rx_is_ctl,
	input wire pcs_code_pkg::code_byte_t rx_data,
	input wire logic idle_match,
	output logic gmii_rx_en,
	output logic gmii_rx_er,
	output logic [7:0] gmii_rx_data
);

	always_ff @(posedge clk_125mhz) begin
		if (!rst_n) begin
			gmii_rx_en <= 1'b0;
			gmii_rx_er <= 1'b0;
			gmii_rx_data <= '0;
		end else begin
			gmii_rx_er <= 1'b0;	// Error is a pulse
			if (rx_valid) begin
				if (rx_is_ctl && rx_data == pcs_code_pkg::k27_7) begin
					gmii_rx_en <= 1'b1;
					gmii_rx_data <= pcs_code_pkg::preamble_byte;	// Restore first preamble byte
				end else if (gmii_rx_en && idle_match) begin
					gmii_rx_en <= 1'b0;	// Idles mid frame, cut it short
					gmii_rx_er <= 1'b1;
				end else if (gmii_rx_en) begin
					if (rx_is_ctl && rx_data == pcs_code_pkg::k29_7)
						gmii_rx_en <= 1'b0;	// End of packet
					else if (rx_is_ctl && rx_data == pcs_code_pkg::k30_7)
						gmii_rx_er <= 1'b1;
					else if (!rx_is_ctl)
						gmii_rx_data <= rx_data;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/gig_basex_pcs.sv
`default_nettype none
`timescale 1ns/10ps

module gig_basex_pcs #(
	parameter int LINK_TIMER_CYCLES = 1250000
) (
	input wire logic clk_125mhz,
	input wire logic rst_n,
	input wire logic rx_valid,	// SERDES receive
	input wire logic rx_is_ctl,
	input wire pcs_code_pkg::code_byte_t rx_data,
	input wire logic gmii_tx_en,	// GMII transmit
	input wire logic [7:0] gmii_tx_data,
	input wire logic tx_disparity_negative,
	output logic tx_is_ctl,	// SERDES transmit
	output pcs_code_pkg::code_byte_t tx_data,
	output logic tx_force_disparity_negative,
	output logic gmii_rx_en,	// GMII receive
	output logic gmii_rx_er,
	output logic [7:0] gmii_rx_data,
	output logic link_up
);

	logic cfg_valid;
	pcs_aneg_pkg::cfg_word_t cfg_word;
	logic idle_match;
	logic timer_start;
	logic timer_done;
	logic send_idle;
	pcs_aneg_pkg::cfg_word_t tx_cfg;

	rx_ordered_set_parser u_parser (.clk_125mhz, .rst_n, .rx_valid, .rx_is_ctl, .rx_data,
		.cfg_valid, .cfg_word, .idle_match);

	aneg_fsm u_aneg (.clk_125mhz, .rst_n, .cfg_valid, .cfg_word, .idle_match, .timer_done,
		.timer_start, .link_up, .send_idle, .tx_cfg);

	link_timer #(.LINK_TIMER_CYCLES(LINK_TIMER_CYCLES)) u_timer (.clk_125mhz, .rst_n,
		.timer_start, .timer_done);

	tx_encoder u_tx (.clk_125mhz, .rst_n, .link_up, .send_idle, .tx_cfg, .gmii_tx_en,
		.gmii_tx_data, .tx_disparity_negative, .tx_is_ctl, .tx_data,
		.tx_force_disparity_negative);

	rx_frame_decoder u_rx (.clk_125mhz, .rst_n, .rx_valid, .rx_is_ctl, .rx_data, .idle_match,
		.gmii_rx_en, .gmii_rx_er, .gmii_rx_data);

endmodule

`default_nettype wire

//--- test/tb_gig_basex_pcs.sv
`default_nettype none
`timescale 1ns/10ps

module tb_gig_basex_pcs;

	logic clk_125mhz;
	logic rst_n;
	logic rx_valid = 1'b0;	// Driven by the partner model only
	logic rx_is_ctl = 1'b0;
	logic [7:0] rx_data = 8'h00;
	logic gmii_tx_en;
	logic [7:0] gmii_tx_data;
	logic tx_disparity_negative;
	logic tx_is_ctl;
	logic [7:0] tx_data;
	logic tx_force_disparity_negative;
	logic gmii_rx_en;
	logic gmii_rx_er;
	logic [7:0] gmii_rx_data;
	logic link_up;

	integer seed = 81;
	integer error_count = 0;
	integer test_errors = 0;
	integer test_num = 0;
	integer failed_tests = 0;
	logic [7:0] frame_bytes [0:255];

	// Partner model state
	logic [1:0] partner_mode = 2'd0;	// 0 silent, 1 config, 2 idle
	logic [15:0] partner_cfg = 16'h0000;
	logic [8:0] rx_q [$];	// {is_ctl, byte} burst, sent on an idle boundary
	logic [8:0] ent;
	logic burst = 1'b0;
	logic [2:0] pphase = 3'd0;
	logic [1:0] last_mode = 2'd0;

	gig_basex_pcs #(.LINK_TIMER_CYCLES(200)) u_dut (.clk_125mhz, .rst_n, .rx_valid, .rx_is_ctl,
		.rx_data, .gmii_tx_en, .gmii_tx_data, .tx_disparity_negative, .tx_is_ctl, .tx_data,
		.tx_force_disparity_negative, .gmii_rx_en, .gmii_rx_er, .gmii_rx_data, .link_up);

	initial begin
		clk_125mhz = 1'b0;
		forever #4 clk_125mhz = ~clk_125mhz;
	end

	initial begin
		#1000000;
		$display("simulation ran past its time limit");
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Partner model

	always @(posedge clk_125mhz) begin
		if (partner_mode != last_mode)
			pphase = 3'd0;	// New stream starts on a set boundary
		last_mode = partner_mode;
		if (rx_q.size() > 0 && (burst || !pphase[0])) begin
			ent = rx_q.pop_front();
			rx_valid <= 1'b1;
			rx_is_ctl <= ent[8];
			rx_data <= ent[7:0];
			burst = (rx_q.size() > 0);
			pphase = 3'd0;
		end else if (partner_mode == 2'd1) begin
			rx_valid <= 1'b1;
			rx_is_ctl <= (pphase == 3'd0 || pphase == 3'd4);
			case (pphase)
				3'd0, 3'd4: rx_data <= pcs_code_pkg::k28_5;
				3'd1: rx_data <= pcs_code_pkg::d21_5;	// /C1/
				3'd5: rx_data <= pcs_code_pkg::d2_2;	// /C2/
				3'd2, 3'd6: rx_data <= partner_cfg[7:0];
				default: rx_data <= partner_cfg[15:8];
			endcase
			pphase = pphase + 3'd1;
		end else if (partner_mode == 2'd2) begin
			rx_valid <= 1'b1;
			rx_is_ctl <= !pphase[0];
			rx_data <= pphase[0] ? pcs_code_pkg::d16_2 : pcs_code_pkg::k28_5;	// /I2/
			pphase = pphase + 3'd1;
		end else
			rx_valid <= 1'b0;
	end

	////////////////////////////////////////
	// Checking helpers

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
			error_count = error_count + 1;
			test_errors = test_errors + 1;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		error_count = error_count + 1;
		test_errors = test_errors + 1;
	endtask

	task automatic apply_reset();
		partner_mode = 2'd0;
		rx_q.delete();
		@(posedge clk_125mhz);
		rst_n <= 1'b0;
		repeat (4) @(posedge clk_125mhz);
		rst_n <= 1'b1;
	endtask

	// Next config word on tx_data, found after a comma and D21.5
	task automatic capture_tx_cfg(output logic [15:0] word, output logic ok);
		integer n;
		integer st;
		logic [7:0] lo;
		ok = 1'b0;
		n = 0;
		st = 0;
		lo = 8'h00;
		word = 16'h0000;
		while (!ok && n < 64) begin
			@(negedge clk_125mhz);
			n = n + 1;
			case (st)
				0: if (tx_is_ctl && tx_data == pcs_code_pkg::k28_5) st = 1;
				1: begin
					if (!tx_is_ctl && tx_data == pcs_code_pkg::d21_5)
						st = 2;
					else if (!(tx_is_ctl && tx_data == pcs_code_pkg::k28_5))
						st = 0;
				end
				2: begin
					lo = tx_data;
					st = 3;
				end
				default: begin
					word = {tx_data, lo};
					ok = 1'b1;
				end
			endcase
		end
	endtask

	// The /C2/ set right behind a captured /C1/ set
	task automatic check_c2_set(input logic [15:0] word);
		@(negedge clk_125mhz);
		check_value("tx_is_ctl", 32'(tx_is_ctl), 32'd1);
		check_value("tx_data", 32'(tx_data), 32'(pcs_code_pkg::k28_5));
		@(negedge clk_125mhz);
		check_value("tx_is_ctl", 32'(tx_is_ctl), 32'd0);
		check_value("tx_data", 32'(tx_data), 32'(pcs_code_pkg::d2_2));
		@(negedge clk_125mhz);
		check_value("tx_data", 32'(tx_data), 32'(word[7:0]));	// Low byte first
		@(negedge clk_125mhz);
		check_value("tx_data", 32'(tx_data), 32'(word[15:8]));
	endtask

	task automatic wait_tx_cfg(input logic [15:0] exp, input integer limit);
		integer n;
		logic [15:0] w;
		logic ok;
		n = 0;
		w = 16'h0000;
		ok = 1'b0;
		while (n < limit && !(ok && w == exp)) begin
			capture_tx_cfg(w, ok);
			n = n + 64;
		end
		if (!ok)
			report_problem("no config set found on the transmit stream");
		else
			check_value("tx_cfg", 32'(w), 32'(exp));
	endtask

	task automatic wait_link(input logic exp, input integer limit);
		integer n;
		n = 0;
		while (link_up !== exp && n < limit) begin
			@(negedge clk_125mhz);
			n = n + 1;
		end
		if (link_up !== exp)
			report_problem($sformatf("link_up did not reach %0d within %0d cycles", exp, limit));
	endtask

	////////////////////////////////////////
	// Frame tasks

	task automatic drive_tx_frame(input integer len);
		integer i;
		for (i = 0; i < len; i = i + 1) begin
			@(posedge clk_125mhz);
			gmii_tx_en <= 1'b1;
			gmii_tx_data <= frame_bytes[i];
		end
		@(posedge clk_125mhz);
		gmii_tx_en <= 1'b0;
		gmii_tx_data <= 8'h00;
	endtask

	task automatic watch_tx_frame(input integer len, input logic exp_force);
		integer n;
		integer i;
		logic found;
		found = 1'b0;
		n = 0;
		while (!found && n < 20) begin
			@(negedge clk_125mhz);
			n = n + 1;
			check_value("tx_force_disparity_negative", 32'(tx_force_disparity_negative),
				32'(exp_force));
			if (tx_is_ctl && tx_data == pcs_code_pkg::k27_7)
				found = 1'b1;
		end
		if (!found)
			report_problem("start symbol never appeared on the transmit stream");
		else begin
			for (i = 1; i < len; i = i + 1) begin	// First byte became the start symbol
				@(negedge clk_125mhz);
				check_value("tx_is_ctl", 32'(tx_is_ctl), 32'd0);
				check_value("tx_data", 32'(tx_data), 32'(frame_bytes[i]));
				check_value("tx_force_disparity_negative",
					32'(tx_force_disparity_negative), 32'(exp_force));
			end
			@(negedge clk_125mhz);
			check_value("tx_is_ctl", 32'(tx_is_ctl), 32'd1);
			check_value("tx_data", 32'(tx_data), 32'(pcs_code_pkg::k29_7));
			@(negedge clk_125mhz);
			check_value("tx_data", 32'(tx_data), 32'(pcs_code_pkg::k23_7));
			@(negedge clk_125mhz);	// Disparity held negative, so /I2/ follows
			check_value("tx_is_ctl", 32'(tx_is_ctl), 32'd1);
			check_value("tx_data", 32'(tx_data), 32'(pcs_code_pkg::k28_5));
		end
	endtask

	task automatic watch_rx_frame(input integer len, input logic exp_er);
		integer n;
		integer i;
		n = 0;
		while (!gmii_rx_en && n < 40) begin
			@(negedge clk_125mhz);
			n = n + 1;
		end
		if (!gmii_rx_en)
			report_problem("gmii_rx_en never rose for the received frame");
		else begin
			check_value("gmii_rx_data", 32'(gmii_rx_data), 32'h55);
			check_value("gmii_rx_er", 32'(gmii_rx_er), 32'(exp_er));
			for (i = 0; i < len; i = i + 1) begin
				@(negedge clk_125mhz);
				check_value("gmii_rx_en", 32'(gmii_rx_en), 32'd1);
				check_value("gmii_rx_data", 32'(gmii_rx_data), 32'(frame_bytes[i]));
				check_value("gmii_rx_er", 32'(gmii_rx_er), 32'(exp_er));
			end
			@(negedge clk_125mhz);
			check_value("gmii_rx_en", 32'(gmii_rx_en), 32'd0);
			check_value("gmii_rx_er", 32'(gmii_rx_er), 32'(exp_er));
		end
	endtask

	task automatic fill_frame(input integer len);
		integer i;
		for (i = 0; i < len; i = i + 1)
			frame_bytes[i] = 8'($random(seed));
	endtask

	////////////////////////////////////////
	// One line of the test file

	task automatic run_test(input string op, input logic [15:0] word, input integer count,
		input logic [15:0] exp_val);
		integer i;
		if (op == "CFG") begin
			partner_cfg = word;
			partner_mode = (count == 0) ? 2'd0 : 2'd1;
			wait_tx_cfg(exp_val, 2000);
			repeat (count * 8) @(negedge clk_125mhz);	// Keep the partner talking
		end else if (op == "IDLE") begin
			if (word != 16'h0000)
				apply_reset();
			@(negedge clk_125mhz);
			partner_mode = 2'd2;
			wait_link(exp_val[0], count);
		end else if (op == "TXFRAME") begin
			fill_frame(count);
			@(negedge clk_125mhz);
			fork
				drive_tx_frame(count);
				watch_tx_frame(count, exp_val[0]);
			join
		end else if (op == "RXFRAME") begin
			fill_frame(count);
			@(negedge clk_125mhz);
			rx_q.push_back({1'b1, pcs_code_pkg::k27_7});
			for (i = 0; i < count; i = i + 1)
				rx_q.push_back({1'b0, frame_bytes[i]});
			rx_q.push_back({1'b1, pcs_code_pkg::k29_7});
			watch_rx_frame(count, exp_val[0]);
		end else if (op == "DROP") begin
			@(negedge clk_125mhz);
			rx_q.push_back({1'b1, pcs_code_pkg::k28_5});	// One /C1/ set
			rx_q.push_back({1'b0, pcs_code_pkg::d21_5});
			rx_q.push_back({1'b0, word[7:0]});
			rx_q.push_back({1'b0, word[15:8]});
			wait_link(exp_val[0], count);
			partner_mode = 2'd0;
		end else
			report_problem($sformatf("unknown operation %s in test file", op));
	endtask

	task automatic close_test(input string name);
		if (test_errors == 0)
			$display("test %0d %s: passed", test_num, name);
		else begin
			$display("test %0d %s: failed with %0d errors", test_num, name, test_errors);
			failed_tests = failed_tests + 1;
		end
		test_num = test_num + 1;
		test_errors = 0;
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin : main
		integer fd;
		integer fields;
		string line;
		string op;
		logic [15:0] word;
		integer count;
		logic [15:0] exp_val;
		logic [15:0] w;
		logic ok;
		rst_n = 1'b0;
		gmii_tx_en = 1'b0;
		gmii_tx_data = 8'h00;
		tx_disparity_negative = 1'b1;
		apply_reset();

		// Fresh from reset the PCS advertises config 0
		@(negedge clk_125mhz);
		check_value("link_up", 32'(link_up), 32'd0);
		capture_tx_cfg(w, ok);
		if (!ok)
			report_problem("no config set after reset");
		else begin
			check_value("tx_cfg", 32'(w), 32'h0);
			check_c2_set(16'h0000);
		end
		capture_tx_cfg(w, ok);
		if (!ok)
			report_problem("config sets did not repeat after reset");
		else
			check_value("tx_cfg", 32'(w), 32'h0);
		close_test("RESET");

		fd = $fopen("test/pcs_tests.txt", "r");
		if (fd == 0)
			report_problem("could not open test/pcs_tests.txt");
		else begin
			while (!$feof(fd)) begin
				line = "";
				fields = $fgets(line, fd);
				if (line.len() > 1 && line[0] != 8'h23) begin	// Skip blanks and # lines
					fields = $sscanf(line, "%s %h %d %h", op, word, count, exp_val);
					if (fields != 4)
						report_problem("malformed line in test file");
					else
						run_test(op, word, count, exp_val);
					close_test(op);
				end
			end
			$fclose(fd);
		end

		$display("%0d tests run, %0d failed, %0d errors", test_num, failed_tests, error_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/pcs_code_pkg.sv
verilog/pcs_aneg_pkg.sv
verilog/link_timer.sv
verilog/rx_ordered_set_parser.sv
verilog/aneg_fsm.sv
verilog/tx_encoder.sv
verilog/rx_frame_decoder.sv
verilog/gig_basex_pcs.sv
test/tb_gig_basex_pcs.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PCS testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_gig_basex_pcs \
	-f list.f --Mdir obj_dir -o sim_tb || exit 1
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

//--- test/pcs_tests.txt
# op word count expect
# CFG: partner word, sets sent after tx config matches, expected tx config word
# IDLE: word 1 resets first, count is a timeout in cycles, expect is link_up
# TXFRAME/RXFRAME: count is the frame length, expect is force disparity / gmii_rx_er
# DROP: word goes out in one config set, count is a timeout, expect is link_up
CFG 0000 0 0020
CFG 0020 12 4020
CFG 4020 6 4020
IDLE 0000 2000 0001
TXFRAME 0000 16 0000
RXFRAME 0000 20 0000
TXFRAME 0000 5 0000
DROP 0020 400 0000
IDLE 0001 2000 0001
TXFRAME 0000 32 0000
RXFRAME 0000 9 0000
DROP 0020 400 0000
